//--- source/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// architectural register count
`define NUM_REGS 32

// reorder buffer size, tag width covers one entry index
`define ROB_DEPTH 8
`define ROB_TAG_W 3

// datapath width
`define XLEN 32

`endif

//--- source/rename_pkg.sv
`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

  // architectural register number, id 0 means no destination
  typedef logic [4:0] reg_id_t;

  // reorder buffer tag, same as the entry index
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

  // data value
  typedef logic [`XLEN-1:0] word_t;

  // occupancy, one bit wider than a tag so a full buffer fits
  typedef logic [`ROB_TAG_W:0] rob_cnt_t;

endpackage

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module reg_file (
  input  wire logic               clk_in,
  input  wire logic               rst_in,
  input  wire logic               flush,

  // source registers of the issuing instruction
  input  wire rename_pkg::reg_id_t  rs1,
  input  wire rename_pkg::reg_id_t  rs2,

  // rename of a destination
  input  wire logic               alloc_fire,
  input  wire rename_pkg::reg_id_t  alloc_rd,
  input  wire rename_pkg::rob_tag_t alloc_tag,

  // in-order retirement from the ROB
  input  wire logic               commit_valid,
  input  wire rename_pkg::reg_id_t  commit_rd,
  input  wire rename_pkg::rob_tag_t commit_tag,
  input  wire rename_pkg::word_t    commit_val,

  // lookup of pending writers in the ROB
  output rename_pkg::rob_tag_t    look1_tag,
  output rename_pkg::rob_tag_t    look2_tag,
  input  wire logic               look1_done,
  input  wire rename_pkg::word_t    look1_val,
  input  wire logic               look2_done,
  input  wire rename_pkg::word_t    look2_val,

  // resolved operands
  output rename_pkg::word_t       op1_val,
  output logic                    op1_busy,
  output rename_pkg::rob_tag_t    op1_tag,
  output rename_pkg::word_t       op2_val,
  output logic                    op2_busy,
  output rename_pkg::rob_tag_t    op2_tag
);

  import rename_pkg::*;

  word_t    regs_q    [`NUM_REGS];
  rob_tag_t tag_q     [`NUM_REGS];
  logic     renamed_q [`NUM_REGS];

  logic     commit_wr;
  logic     alloc_wr;
  logic     commit_untag;

  // value seen by a reader of rs
  // a done pending writer forwards its ROB result
  function automatic word_t operand_val(input reg_id_t rs, input logic done,
                                        input word_t fwd);
    word_t val;
    if (rs == '0) begin
      val = '0;
    end else if (renamed_q[rs] && done) begin
      val = fwd;
    end else begin
      val = regs_q[rs];
    end
    return val;
  endfunction

  // still waiting on a writer that has no result yet
  function automatic logic operand_busy(input reg_id_t rs, input logic done);
    return (rs != '0) && renamed_q[rs] && !done;
  endfunction

  assign look1_tag = tag_q[rs1];
  assign look2_tag = tag_q[rs2];

  assign op1_val  = operand_val(rs1, look1_done, look1_val);
  assign op1_busy = operand_busy(rs1, look1_done);
  assign op1_tag  = tag_q[rs1];

  assign op2_val  = operand_val(rs2, look2_done, look2_val);
  assign op2_busy = operand_busy(rs2, look2_done);
  assign op2_tag  = tag_q[rs2];

  // register 0 is never written nor renamed
  assign commit_wr = commit_valid && (commit_rd != '0);
  assign alloc_wr  = alloc_fire && (alloc_rd != '0);

  // drop the tag only if this commit is the newest writer
  // and the same register is not renamed again this cycle
  assign commit_untag = commit_wr && (tag_q[commit_rd] == commit_tag) &&
                        !(alloc_wr && (alloc_rd == commit_rd));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i]    <= '0;
        tag_q[i]     <= '0;
        renamed_q[i] <= 1'b0;
      end
    end else begin
      if (commit_wr) begin
        regs_q[commit_rd] <= commit_val;
      end
      if (commit_untag) begin
        renamed_q[commit_rd] <= 1'b0;
      end
      if (flush) begin
        // speculative writers are gone, committed values stay
        for (int i = 0; i < `NUM_REGS; i++) begin
          renamed_q[i] <= 1'b0;
        end
      end else if (alloc_wr) begin
        renamed_q[alloc_rd] <= 1'b1;
        tag_q[alloc_rd]     <= alloc_tag;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module reorder_buffer (
  input  wire logic               clk_in,
  input  wire logic               rst_in,
  input  wire logic               flush_in,

  // issue request from upstream
  input  wire logic               issue_valid,
  input  wire rename_pkg::reg_id_t  issue_rd,
  output logic                    issue_ready,

  // rename towards the register file
  output logic                    alloc_fire,
  output rename_pkg::reg_id_t     alloc_rd,
  output rename_pkg::rob_tag_t    alloc_tag,

  // results, out of order
  input  wire logic               result_valid,
  input  wire rename_pkg::rob_tag_t result_tag,
  input  wire rename_pkg::word_t    result_val,

  // retirement of the head entry
  output logic                    commit_valid,
  output rename_pkg::reg_id_t     commit_rd,
  output rename_pkg::rob_tag_t    commit_tag,
  output rename_pkg::word_t       commit_val,

  // operand lookups
  input  wire rename_pkg::rob_tag_t look1_tag,
  input  wire rename_pkg::rob_tag_t look2_tag,
  output logic                    look1_done,
  output rename_pkg::word_t       look1_val,
  output logic                    look2_done,
  output rename_pkg::word_t       look2_val
);

  import rename_pkg::*;

  rob_tag_t head_q;
  rob_tag_t tail_q;
  rob_cnt_t count_q;

  logic [`ROB_DEPTH-1:0] valid_q;
  logic [`ROB_DEPTH-1:0] done_q;
  reg_id_t               rd_q  [`ROB_DEPTH];
  word_t                 val_q [`ROB_DEPTH];

  logic result_hit;

  // full buffer or flush stalls the issue port
  assign issue_ready = (count_q != rob_cnt_t'(`ROB_DEPTH)) && !flush_in;
  assign alloc_fire  = issue_valid && issue_ready;
  assign alloc_rd    = issue_rd;
  // tag is simply the tail index
  assign alloc_tag   = tail_q;

  // results for unallocated tags are dropped
  assign result_hit = result_valid && valid_q[result_tag];

  assign commit_valid = valid_q[head_q] && done_q[head_q] && !flush_in;
  assign commit_rd    = rd_q[head_q];
  assign commit_tag   = head_q;
  assign commit_val   = val_q[head_q];

  assign look1_done = valid_q[look1_tag] && done_q[look1_tag];
  assign look1_val  = val_q[look1_tag];
  assign look2_done = valid_q[look2_tag] && done_q[look2_tag];
  assign look2_val  = val_q[look2_tag];

  // pointers and occupancy
  always_ff @(posedge clk_in) begin
    if (rst_in || flush_in) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_fire) begin
        tail_q <= tail_q + 1'b1;
      end
      if (commit_valid) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc_fire, commit_valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // per-entry status bits
  always_ff @(posedge clk_in) begin
    if (rst_in || flush_in) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (result_hit) begin
        done_q[result_tag] <= 1'b1;
      end
      if (commit_valid) begin
        valid_q[head_q] <= 1'b0;
        done_q[head_q]  <= 1'b0;
      end
      // a fresh entry starts not done
      if (alloc_fire) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_in) begin
    if (alloc_fire) begin
      rd_q[tail_q] <= issue_rd;
    end
    if (result_hit) begin
      val_q[result_tag] <= result_val;
    end
  end

endmodule

`default_nettype wire

//--- source/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
  input  wire logic               clk_in,
  input  wire logic               rst_in,
  input  wire logic               flush_in,

  // issue port
  input  wire logic               issue_valid,
  input  wire rename_pkg::reg_id_t  issue_rd,
  input  wire rename_pkg::reg_id_t  issue_rs1,
  input  wire rename_pkg::reg_id_t  issue_rs2,
  output logic                    issue_ready,
  output rename_pkg::rob_tag_t    issue_tag,

  // operands of the issuing instruction
  output rename_pkg::word_t       op1_val,
  output logic                    op1_busy,
  output rename_pkg::rob_tag_t    op1_tag,
  output rename_pkg::word_t       op2_val,
  output logic                    op2_busy,
  output rename_pkg::rob_tag_t    op2_tag,

  // result port, never stalls
  input  wire logic               result_valid,
  input  wire rename_pkg::rob_tag_t result_tag,
  input  wire rename_pkg::word_t    result_val,

  // commit port
  output logic                    commit_valid,
  output rename_pkg::reg_id_t     commit_rd,
  output rename_pkg::word_t       commit_val
);

  import rename_pkg::*;

  logic     alloc_fire;
  reg_id_t  alloc_rd;
  rob_tag_t commit_tag;
  rob_tag_t look1_tag;
  rob_tag_t look2_tag;
  logic     look1_done;
  logic     look2_done;
  word_t    look1_val;
  word_t    look2_val;

  reorder_buffer u_rob (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .flush_in     (flush_in),
    .issue_valid  (issue_valid),
    .issue_rd     (issue_rd),
    .issue_ready  (issue_ready),
    .alloc_fire   (alloc_fire),
    .alloc_rd     (alloc_rd),
    .alloc_tag    (issue_tag),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_val   (result_val),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_tag   (commit_tag),
    .commit_val   (commit_val),
    .look1_tag    (look1_tag),
    .look2_tag    (look2_tag),
    .look1_done   (look1_done),
    .look1_val    (look1_val),
    .look2_done   (look2_done),
    .look2_val    (look2_val)
  );

  // the allocated tag doubles as the issue tag
  reg_file u_regs (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .flush        (flush_in),
    .rs1          (issue_rs1),
    .rs2          (issue_rs2),
    .alloc_fire   (alloc_fire),
    .alloc_rd     (alloc_rd),
    .alloc_tag    (issue_tag),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_tag   (commit_tag),
    .commit_val   (commit_val),
    .look1_tag    (look1_tag),
    .look2_tag    (look2_tag),
    .look1_done   (look1_done),
    .look1_val    (look1_val),
    .look2_done   (look2_done),
    .look2_val    (look2_val),
    .op1_val      (op1_val),
    .op1_busy     (op1_busy),
    .op1_tag      (op1_tag),
    .op2_val      (op2_val),
    .op2_busy     (op2_busy),
    .op2_tag      (op2_tag)
  );

endmodule

`default_nettype wire

//--- sim/rename_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_core_asserts (
  input  wire logic                  clk_in,
  input  wire logic                  rst_in,
  input  wire logic                  flush_in,
  input  wire logic                  issue_ready,
  input  wire logic                  commit_valid,
  input  wire logic [`ROB_DEPTH-1:0] rob_valid
);

  int assert_fails = 0;

  // every entry taken or a flush holds off the issue port
  a_issue_stall: assert property (@(posedge clk_in) disable iff (rst_in)
    ((&rob_valid) || flush_in) |-> !issue_ready)
    else begin
      assert_fails++;
      $error("issue_ready high with a full ROB or during a flush");
    end

  // nothing retires while speculative state is dropped, nor right after
  a_no_commit_in_flush: assert property (@(posedge clk_in) disable iff (rst_in)
    flush_in |-> !commit_valid ##1 !commit_valid)
    else begin
      assert_fails++;
      $error("commit_valid high in a flush cycle or the cycle after it");
    end

  a_quiet_after_reset: assert property (@(posedge clk_in)
    $fell(rst_in) |-> !commit_valid)
    else begin
      assert_fails++;
      $error("commit_valid high in the first cycle after reset");
    end

endmodule

bind rename_core rename_core_asserts u_asserts (
  .clk_in       (clk_in),
  .rst_in       (rst_in),
  .flush_in     (flush_in),
  .issue_ready  (issue_ready),
  .commit_valid (commit_valid),
  .rob_valid    (u_rob.valid_q)
);

`default_nettype wire

//--- sim/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_core_tb;

  import rename_pkg::*;

  localparam int OPW = 1 + `ROB_TAG_W + `XLEN;
  localparam int WAIT_LIMIT = 60;

  logic     clk_in;
  logic     rst_in;
  logic     flush_in;
  logic     issue_valid;
  reg_id_t  issue_rd;
  reg_id_t  issue_rs1;
  reg_id_t  issue_rs2;
  logic     issue_ready;
  rob_tag_t issue_tag;
  word_t    op1_val;
  logic     op1_busy;
  rob_tag_t op1_tag;
  word_t    op2_val;
  logic     op2_busy;
  rob_tag_t op2_tag;
  logic     result_valid;
  rob_tag_t result_tag;
  word_t    result_val;
  logic     commit_valid;
  reg_id_t  commit_rd;
  word_t    commit_val;

  // reference model of registers and ROB
  word_t    m_regs    [`NUM_REGS];
  logic     m_renamed [`NUM_REGS];
  rob_tag_t m_tag     [`NUM_REGS];
  logic [`ROB_DEPTH-1:0] m_valid;
  logic [`ROB_DEPTH-1:0] m_done;
  reg_id_t  m_rd      [`ROB_DEPTH];
  word_t    m_val     [`ROB_DEPTH];
  rob_tag_t m_head;
  rob_tag_t m_tail;
  int       m_count;

  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          expect_tag;
  logic        exp_ready;
  logic        exp_commit;

  rename_core UUT (.*);

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  // {busy, tag, value} as a reader of rs should see it
  function automatic logic [OPW-1:0] expected_operand(input reg_id_t rs);
    rob_tag_t t;
    logic [OPW-1:0] res;
    t = m_tag[rs];
    if (rs == '0) begin
      res = {1'b0, t, word_t'(0)};
    end else if (!m_renamed[rs]) begin
      res = {1'b0, t, m_regs[rs]};
    end else if (m_valid[t] && m_done[t]) begin
      res = {1'b0, t, m_val[t]};
    end else begin
      res = {1'b1, t, m_regs[rs]};
    end
    return res;
  endfunction

  task automatic compare_operand(input string name, input word_t got_val, input logic got_busy,
                                 input rob_tag_t got_tag, input logic [OPW-1:0] exp);
    logic     exp_busy;
    rob_tag_t exp_tag;
    word_t    exp_val;
    {exp_busy, exp_tag, exp_val} = exp;
    checks++;
    if (got_busy !== exp_busy) report_mismatch({name, "_busy"}, got_busy, exp_busy);
    if (exp_busy && got_tag !== exp_tag) report_mismatch({name, "_tag"}, got_tag, exp_tag);
    if (!exp_busy && got_val !== exp_val) report_mismatch({name, "_val"}, got_val, exp_val);
  endtask

  // one clock edge of the model, from the inputs seen at that edge
  task automatic advance_model();
    logic fire;
    logic cmt;
    reg_id_t crd;
    fire = issue_valid && (m_count != `ROB_DEPTH) && !flush_in;
    cmt = m_valid[m_head] && m_done[m_head] && !flush_in;
    crd = m_rd[m_head];
    if (rst_in || flush_in) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        if (rst_in) m_regs[i] = '0;
        if (rst_in) m_tag[i] = '0;
        m_renamed[i] = 1'b0;
      end
      m_valid = '0;
      m_done = '0;
      m_head = '0;
      m_tail = '0;
      m_count = 0;
    end else begin
      if (cmt && crd != '0) begin
        m_regs[crd] = m_val[m_head];
        // a rename of the same register in this cycle wins
        if (m_tag[crd] == m_head && !(fire && issue_rd == crd)) m_renamed[crd] = 1'b0;
      end
      if (fire && issue_rd != '0) begin
        m_renamed[issue_rd] = 1'b1;
        m_tag[issue_rd] = m_tail;
      end
      if (result_valid && m_valid[result_tag]) begin
        m_done[result_tag] = 1'b1;
        m_val[result_tag] = result_val;
      end
      if (cmt) begin
        m_valid[m_head] = 1'b0;
        m_done[m_head] = 1'b0;
        m_head = m_head + 1'b1;
        m_count--;
      end
      if (fire) begin
        m_valid[m_tail] = 1'b1;
        m_done[m_tail] = 1'b0;
        m_rd[m_tail] = issue_rd;
        m_tail = m_tail + 1'b1;
        m_count++;
      end
    end
  endtask

  always @(posedge clk_in) advance_model();

  // outputs are settled by the falling edge
  always @(negedge clk_in) begin
    if (!rst_in) begin
      exp_ready = (m_count != `ROB_DEPTH) && !flush_in;
      exp_commit = m_valid[m_head] && m_done[m_head] && !flush_in;
      compare_operand("op1", op1_val, op1_busy, op1_tag, expected_operand(issue_rs1));
      compare_operand("op2", op2_val, op2_busy, op2_tag, expected_operand(issue_rs2));
      checks++;
      if (issue_ready !== exp_ready) report_mismatch("issue_ready", issue_ready, exp_ready);
      if (issue_tag !== m_tail) report_mismatch("issue_tag", issue_tag, m_tail);
      if (commit_valid !== exp_commit) begin
        report_mismatch("commit_valid", commit_valid, exp_commit);
      end
      if (exp_commit && commit_rd !== m_rd[m_head]) begin
        report_mismatch("commit_rd", commit_rd, m_rd[m_head]);
      end
      if (exp_commit && commit_val !== m_val[m_head]) begin
        report_mismatch("commit_val", commit_val, m_val[m_head]);
      end
    end
  end

  task automatic issue_checked(input reg_id_t rd, input reg_id_t rs1, input reg_id_t rs2);
    int n;
    logic fired;
    rob_tag_t got;
    n = 0;
    fired = 1'b0;
    issue_valid = 1'b1;
    issue_rd = rd;
    issue_rs1 = rs1;
    issue_rs2 = rs2;
    while (!fired) begin
      @(negedge clk_in);
      fired = issue_ready;
      got = issue_tag;
      @(posedge clk_in);
      #1;
      n++;
      if (!fired && n > WAIT_LIMIT) timed_out("an issue slot");
    end
    issue_valid = 1'b0;
    if (got !== rob_tag_t'(expect_tag)) report_mismatch("issue_tag", got, expect_tag);
    expect_tag = (expect_tag + 1) % `ROB_DEPTH;
  endtask

  task automatic deliver(input int tag);
    logic [31:0] v;
    take_bits(32, v);
    result_valid = 1'b1;
    result_tag = rob_tag_t'(tag);
    result_val = v;
    @(posedge clk_in);
    #1;
    result_valid = 1'b0;
  endtask

  // read every register, optionally demanding that none is busy
  task automatic sweep_regs(input logic idle);
    for (int i = 0; i < `NUM_REGS; i++) begin
      issue_rs1 = reg_id_t'(i);
      issue_rs2 = reg_id_t'(`NUM_REGS - 1 - i);
      @(negedge clk_in);
      if (idle && op1_busy !== 1'b0) report_mismatch("op1_busy", op1_busy, 0);
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk_in);
    while (issue_ready !== 1'b1) begin
      n++;
      if (n > WAIT_LIMIT) timed_out("issue_ready to rise");
      @(negedge clk_in);
    end
    @(posedge clk_in);
    #1;
  endtask

  task automatic drain_rob();
    int n;
    n = 0;
    @(negedge clk_in);
    while (m_count != 0) begin
      n++;
      if (n > WAIT_LIMIT) timed_out("the ROB to drain");
      @(negedge clk_in);
    end
    @(posedge clk_in);
    #1;
  endtask

  initial begin
    logic [31:0] r;
    int pending[$];
    int j;
    int t;
    rst_in = 1'b1;
    flush_in = 1'b0;
    issue_valid = 1'b0;
    issue_rd = '0;
    issue_rs1 = '0;
    issue_rs2 = '0;
    result_valid = 1'b0;
    result_tag = '0;
    result_val = '0;
    lfsr_q = 32'hb3e7;
    errors = 0;
    checks = 0;
    expect_tag = 0;
    repeat (4) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    sweep_regs(1'b1);

    // fill the ROB, one entry has no destination
    for (int k = 0; k < `ROB_DEPTH; k++) begin
      take_bits(15, r);
      issue_checked((k == 3) ? 5'd0 : r[14:10], r[9:5], r[4:0]);
    end
    sweep_regs(1'b0);

    // full ROB, a held request must not allocate
    issue_valid = 1'b1;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk_in);
      if (issue_ready !== 1'b0) report_mismatch("issue_ready", issue_ready, 0);
      @(posedge clk_in);
      #1;
    end
    issue_valid = 1'b0;

    // forwarded result before commit
    deliver(2);
    sweep_regs(1'b0);
    deliver(0);
    wait_ready();
    take_bits(15, r);
    issue_checked(r[14:10], r[9:5], r[4:0]);

    // remaining results in shuffled order
    for (int k = 0; k < `ROB_DEPTH; k++) begin
      if (m_valid[k] && !m_done[k]) pending.push_back(k);
    end
    for (int k = pending.size() - 1; k > 0; k--) begin
      take_bits(8, r);
      j = r % (k + 1);
      t = pending[j];
      pending[j] = pending[k];
      pending[k] = t;
    end
    foreach (pending[k]) begin
      deliver(pending[k]);
    end
    drain_rob();
    sweep_regs(1'b1);

    // flush with work in flight
    for (int k = 0; k < 4; k++) begin
      take_bits(15, r);
      issue_checked(r[14:10], r[9:5], r[4:0]);
    end
    deliver(3);
    flush_in = 1'b1;
    @(posedge clk_in);
    #1;
    flush_in = 1'b0;
    expect_tag = 0;
    sweep_regs(1'b1);
    for (int k = 1; k <= 4; k++) begin
      deliver(k);
    end
    for (int k = 0; k < 2; k++) begin
      take_bits(15, r);
      issue_checked(r[14:10], r[9:5], r[4:0]);
    end
    deliver(1);
    deliver(0);
    drain_rob();
    sweep_regs(1'b1);

    errors += UUT.u_asserts.assert_fails;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+source
source/rename_pkg.sv
source/reg_file.sv
source/reorder_buffer.sv
source/rename_core.sv
sim/rename_core_asserts.sv
sim/rename_core_tb.sv

//--- Bender.yml
package:
  name: rename_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rename_pkg.sv
      - source/reg_file.sv
      - source/reorder_buffer.sv
      - source/rename_core.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/rename_core_asserts.sv
      - sim/rename_core_tb.sv
